// File: all.f
+incdir+design
design/tcb_pkg.sv
design/tcb_decoder.sv
design/tcb_demux.sv
design/tcb_sram_sub.sv
design/tcb_gpio_sub.sv
design/tcb_subsystem.sv
test/tb_clk_gen.sv
test/tb_tcb_subsystem.sv

// File: Makefile
# Verilator build and run for the tcb subsystem testbench

SIM  = obj_dir/Vtb_tcb_subsystem
SRCS = $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when the file list or a source changes
$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert -f all.f --top-module tb_tcb_subsystem \
		-o Vtb_tcb_subsystem

# pass only if the log holds the pass line
run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qx 'STATUS: PASS' sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_tcb_subsystem.sv
`timescale 1ns/1ps

/*
 * tcb subsystem testbench
 * table of transfers applied back to back, responses checked against a reference model
 */

`include "tcb_macros.svh"

module tb_tcb_subsystem;

    import tcb_pkg::*;

    localparam logic [31:0] GPIO_BASE = 32'h0001_0000;
    // gpio_in values per table section
    localparam logic [31:0] GIN_A = 32'h0000_0000;
    localparam logic [31:0] GIN_B = 32'ha5c3_1e7f;
    localparam logic [31:0] GIN_C = 32'h3c0f_96e1;

    // one table row, err is the expected error flag
    typedef struct packed {
        logic                wen;
        logic [`TCB_ADR-1:0] adr;
        logic [`TCB_BEN-1:0] ben;
        logic [`TCB_DAT-1:0] wdt;
        logic [`TCB_DAT-1:0] gin;
        logic                err;
    } row_t;

    logic                clk;
    logic                arst_n;
    logic                man_vld;
    tcb_req_t            man_req;
    logic                man_rdy;
    logic                man_rsp_vld;
    tcb_rsp_t            man_rsp;
    logic [`TCB_DAT-1:0] gpio_in;
    logic [`TCB_DAT-1:0] gpio_out;

    row_t                rows [$];
    // reference model state
    logic [`TCB_DAT-1:0] ref_mem [256];
    logic [`TCB_DAT-1:0] ref_gpio;
    // error counts per check kind
    int                  err_rsp;
    int                  err_bit;
    int                  err_word;
    int                  err_other;
    // watchdog
    int                  cycles;
    int                  limit;

    tb_clk_gen clk_gen0 (
        .clk    (clk),
        .arst_n (arst_n)
    );

    tcb_subsystem dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .man_vld     (man_vld),
        .man_req     (man_req),
        .man_rdy     (man_rdy),
        .man_rsp_vld (man_rsp_vld),
        .man_rsp     (man_rsp),
        .gpio_in     (gpio_in),
        .gpio_out    (gpio_out)
    );

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_rsp(input string name, input tcb_rsp_t got, input tcb_rsp_t want);
        if (got !== want) begin
            err_rsp++;
            $display("[FAIL] %0t %s got rdt=%h err=%b exp rdt=%h err=%b",
                     $time, name, got.rdt, got.err, want.rdt, want.err);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            err_bit++;
            $display("[FAIL] %0t %s got %b exp %b", $time, name, got, want);
        end
    endtask

    task automatic check_word(input string name, input logic [`TCB_DAT-1:0] got,
                              input logic [`TCB_DAT-1:0] want);
        if (got !== want) begin
            err_word++;
            $display("[FAIL] %0t %s got %h exp %h", $time, name, got, want);
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // 0 memory, 1 gpio, -1 unmapped
    function automatic int region(logic [`TCB_ADR-1:0] adr);
        if (adr < 32'h0000_0400) return 0;
        if (adr >= GPIO_BASE && adr <= GPIO_BASE + 32'd7) return 1;
        return -1;
    endfunction

    function automatic logic [`TCB_DAT-1:0] merge_bytes(logic [`TCB_DAT-1:0] old,
                                                        logic [`TCB_DAT-1:0] wdt,
                                                        logic [`TCB_BEN-1:0] ben);
        logic [`TCB_DAT-1:0] res;
        res = old;
        for (int b = 0; b < `TCB_BEN; b++) begin
            if (ben[b]) res[8*b +: 8] = wdt[8*b +: 8];
        end
        return res;
    endfunction

    // input read is only defined once gpio_in has been held for four rows
    task automatic held_input(input int j, output logic [`TCB_DAT-1:0] val);
        val = rows[j].gin;
        if (j < 3) begin
            err_other++;
            $display("table row %0d reads gpio input too early after start", j);
        end else if (rows[j-1].gin !== val || rows[j-2].gin !== val || rows[j-3].gin !== val) begin
            err_other++;
            $display("table row %0d reads gpio input that was not held stable", j);
        end
    endtask

    // expected response of row j, model state updated as the handshake would
    task automatic predict(input int j, output tcb_rsp_t want);
        row_t       r;
        int         reg_n;
        logic [7:0] w;
        r = rows[j];
        reg_n = region(r.adr);
        w = r.adr[9:2];
        want.rdt = '0;
        want.err = r.err;
        if ((reg_n < 0) !== r.err) begin
            err_other++;
            $display("table row %0d expected err flag disagrees with the memory map", j);
        end
        case (reg_n)
            0: begin
                if (r.wen) ref_mem[w] = merge_bytes(ref_mem[w], r.wdt, r.ben);
                else       want.rdt = ref_mem[w];
            end
            1: begin
                // adr bit 2 set is the input offset, read only
                if (r.adr[2]) begin
                    if (!r.wen) held_input(j, want.rdt);
                end else if (r.wen) begin
                    ref_gpio = merge_bytes(ref_gpio, r.wdt, r.ben);
                end else begin
                    want.rdt = ref_gpio;
                end
            end
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////

    task automatic add_row(input logic wen, input logic [31:0] adr, input logic [3:0] ben,
                           input logic [31:0] wdt, input logic [31:0] gin, input logic err);
        rows.push_back('{wen: wen, adr: adr, ben: ben, wdt: wdt, gin: gin, err: err});
    endtask

    task automatic build_table();
        // memory, full words first so every byte is defined
        add_row(1'b1, 32'h0000_0000, 4'hf, $urandom, GIN_A, 1'b0);
        add_row(1'b1, 32'h0000_0004, 4'hf, $urandom, GIN_A, 1'b0);
        add_row(1'b1, 32'h0000_03fc, 4'hf, $urandom, GIN_A, 1'b0);
        // mixed byte enables
        add_row(1'b1, 32'h0000_0000, 4'b0101, $urandom, GIN_A, 1'b0);
        add_row(1'b1, 32'h0000_0004, 4'b1000, $urandom, GIN_A, 1'b0);
        add_row(1'b1, 32'h0000_03fc, 4'b0110, $urandom, GIN_A, 1'b0);
        add_row(1'b0, 32'h0000_0000, 4'h0, 32'h0, GIN_A, 1'b0);
        add_row(1'b0, 32'h0000_0004, 4'h0, 32'h0, GIN_A, 1'b0);
        add_row(1'b0, 32'h0000_03fc, 4'h0, 32'h0, GIN_A, 1'b0);
        // gpio output register
        add_row(1'b1, GPIO_BASE + `GPIO_OFS_OUT, 4'hf, $urandom, GIN_A, 1'b0);
        add_row(1'b0, GPIO_BASE + `GPIO_OFS_OUT, 4'h0, 32'h0, GIN_A, 1'b0);
        add_row(1'b1, GPIO_BASE + `GPIO_OFS_OUT, 4'b0011, $urandom, GIN_A, 1'b0);
        // write to the input offset is ignored
        add_row(1'b1, GPIO_BASE + `GPIO_OFS_IN, 4'hf, $urandom, GIN_A, 1'b0);
        add_row(1'b0, GPIO_BASE + `GPIO_OFS_OUT, 4'h0, 32'h0, GIN_A, 1'b0);
        // gpio input held four rows, then read
        add_row(1'b0, 32'h0000_0000, 4'h0, 32'h0, GIN_B, 1'b0);
        add_row(1'b0, 32'h0000_0004, 4'h0, 32'h0, GIN_B, 1'b0);
        add_row(1'b0, 32'h0000_03fc, 4'h0, 32'h0, GIN_B, 1'b0);
        add_row(1'b0, GPIO_BASE + `GPIO_OFS_OUT, 4'h0, 32'h0, GIN_B, 1'b0);
        add_row(1'b0, GPIO_BASE + `GPIO_OFS_IN, 4'h0, 32'h0, GIN_B, 1'b0);
        // unmapped reads and writes
        add_row(1'b1, 32'h0000_0400, 4'hf, $urandom, GIN_C, 1'b1);
        add_row(1'b1, GPIO_BASE + 32'h8, 4'hf, $urandom, GIN_C, 1'b1);
        add_row(1'b1, 32'h0002_0000, 4'hf, $urandom, GIN_C, 1'b1);
        add_row(1'b0, 32'h0000_0400, 4'h0, 32'h0, GIN_C, 1'b1);
        add_row(1'b0, 32'hffff_fffc, 4'h0, 32'h0, GIN_C, 1'b1);
        // state unchanged by the misses
        add_row(1'b0, 32'h0000_0000, 4'h0, 32'h0, GIN_C, 1'b0);
        add_row(1'b0, GPIO_BASE + `GPIO_OFS_OUT, 4'h0, 32'h0, GIN_C, 1'b0);
        // back to back reads across all targets
        add_row(1'b0, 32'h0000_0004, 4'h0, 32'h0, GIN_C, 1'b0);
        add_row(1'b0, GPIO_BASE + `GPIO_OFS_OUT, 4'h0, 32'h0, GIN_C, 1'b0);
        add_row(1'b0, 32'h0000_0800, 4'h0, 32'h0, GIN_C, 1'b1);
        add_row(1'b0, 32'h0000_03fc, 4'h0, 32'h0, GIN_C, 1'b0);
        add_row(1'b0, GPIO_BASE + `GPIO_OFS_IN, 4'h0, 32'h0, GIN_C, 1'b0);
        add_row(1'b0, GPIO_BASE + 32'hc, 4'h0, 32'h0, GIN_C, 1'b1);
        add_row(1'b0, 32'h0000_0000, 4'h0, 32'h0, GIN_C, 1'b0);
    endtask

    task automatic apply_row(input row_t r);
        man_vld = 1'b1;
        man_req = '{wen: r.wen, adr: r.adr, ben: r.ben, wdt: r.wdt};
        gpio_in = r.gin;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        tcb_rsp_t pend_rsp;
        logic     pend;
        int       idx;
        man_vld   = 1'b0;
        man_req   = '0;
        gpio_in   = '0;
        ref_gpio  = '0;
        err_rsp   = 0;
        err_bit   = 0;
        err_word  = 0;
        err_other = 0;
        void'($urandom(32'h5855b1bb));
        build_table();
        limit = rows.size() * 4 + 100;

        @(posedge arst_n);
        #1;
        check_bit("man_rsp_vld", man_rsp_vld, 1'b0);
        check_word("gpio_out", gpio_out, '0);

        pend = 1'b0;
        idx  = 0;
        while (idx < rows.size() || pend) begin
            @(negedge clk);
            // response of the previous handshake
            check_bit("man_rsp_vld", man_rsp_vld, pend);
            if (pend) check_rsp("man_rsp", man_rsp, pend_rsp);
            check_word("gpio_out", gpio_out, ref_gpio);
            pend = 1'b0;
            if (idx < rows.size()) begin
                apply_row(rows[idx]);
                // let man_rdy settle before deciding on the handshake
                #1;
                // no wait states, hits and misses are accepted at once
                check_bit("man_rdy", man_rdy, 1'b1);
                if (man_rdy) begin
                    predict(idx, pend_rsp);
                    pend = 1'b1;
                    idx++;
                end
            end else begin
                man_vld = 1'b0;
            end
        end

        // idle bus stays quiet
        repeat (2) begin
            @(negedge clk);
            check_bit("man_rsp_vld", man_rsp_vld, 1'b0);
        end

        $display("errors: rsp %0d bit %0d word %0d other %0d",
                 err_rsp, err_bit, err_word, err_other);
        if (err_rsp + err_bit + err_word + err_other == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog, limit is zero until the table exists
    initial begin
        cycles = 0;
        while (limit == 0 || cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps

/*
 * testbench clock and reset, 10 ns period
 * reset held low for 8 cycles, released on a falling edge
 */

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        // release away from the sampling edge
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: design/tcb_subsystem.sv
`timescale 1ns/1ps

/*
 * tcb subsystem, one manager, memory and gpio subordinates
 * decoder and demux route each transfer by the memory map
 */

`include "tcb_macros.svh"

module tcb_subsystem (
    input  logic                clk,
    input  logic                arst_n,
    // manager port
    input  logic                man_vld,
    input  tcb_pkg::tcb_req_t   man_req,
    output logic                man_rdy,
    output logic                man_rsp_vld,
    output tcb_pkg::tcb_rsp_t   man_rsp,
    // gpio pins
    input  logic [`TCB_DAT-1:0] gpio_in,
    output logic [`TCB_DAT-1:0] gpio_out
);

    import tcb_pkg::*;

    // decoder result
    logic [$clog2(`TCB_IFN)-1:0] sel;
    logic                        hit;
    // subordinate links, index 0 memory, index 1 gpio
    logic [`TCB_IFN-1:0]         sub_vld;
    tcb_req_t                    sub_req;
    logic [`TCB_IFN-1:0]         sub_rdy;
    tcb_rsp_t [`TCB_IFN-1:0]     sub_rsp;

    //////////////////////////////////////////////////
    // address decode and routing
    //////////////////////////////////////////////////

    // table order is {1, 0} so entry 0 is the memory
    tcb_decoder #(
        .IFN (`TCB_IFN),
        .DAM ('{`TCB_DAM_GPIO, `TCB_DAM_SRAM})
    ) decoder0 (
        .adr (man_req.adr),
        .sel (sel),
        .hit (hit)
    );

    tcb_demux #(
        .IFN (`TCB_IFN)
    ) demux0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .man_vld     (man_vld),
        .man_req     (man_req),
        .man_rdy     (man_rdy),
        .man_rsp_vld (man_rsp_vld),
        .man_rsp     (man_rsp),
        .sel         (sel),
        .hit         (hit),
        .sub_vld     (sub_vld),
        .sub_req     (sub_req),
        .sub_rdy     (sub_rdy),
        .sub_rsp     (sub_rsp)
    );

    //////////////////////////////////////////////////
    // subordinates
    //////////////////////////////////////////////////

    // subordinate 0
    tcb_sram_sub #(
        .DEPTH (256)
    ) sram0 (
        .clk (clk),
        .vld (sub_vld[0]),
        .req (sub_req),
        .rdy (sub_rdy[0]),
        .rsp (sub_rsp[0])
    );

    // subordinate 1
    tcb_gpio_sub gpio0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .vld      (sub_vld[1]),
        .req      (sub_req),
        .rdy      (sub_rdy[1]),
        .rsp      (sub_rsp[1]),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

endmodule

// File: design/tcb_gpio_sub.sv
`timescale 1ns/1ps

/*
 * tcb gpio subordinate
 * byte writable output register and a synchronized input register
 */

`include "tcb_macros.svh"

module tcb_gpio_sub (
    input  logic                clk,
    input  logic                arst_n,
    // subordinate port
    input  logic                vld,
    input  tcb_pkg::tcb_req_t   req,
    output logic                rdy,
    output tcb_pkg::tcb_rsp_t   rsp,
    // pins
    input  logic [`TCB_DAT-1:0] gpio_in,
    output logic [`TCB_DAT-1:0] gpio_out
);

    // handshake
    logic                trn;
    // register offset, word aligned
    logic [2:0]          ofs;
    logic                ofs_out;
    logic                ofs_in;
    // input synchronizer
    logic [`TCB_DAT-1:0] gpio_sync0;
    logic [`TCB_DAT-1:0] gpio_sync1;
    // response data register
    logic [`TCB_DAT-1:0] rdt;

    assign rdy = 1'b1;
    assign trn = vld && rdy;

    // only adr bit 2 selects a register, byte lanes come from ben
    assign ofs     = {req.adr[2], 2'b00};
    assign ofs_out = (ofs == 3'(`GPIO_OFS_OUT));
    assign ofs_in  = (ofs == 3'(`GPIO_OFS_IN));

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_out   <= '0;
            gpio_sync0 <= '0;
            gpio_sync1 <= '0;
        end else begin
            // two flop synchronizer on the pins
            gpio_sync0 <= gpio_in;
            gpio_sync1 <= gpio_sync0;
            // byte enabled write, input offset is read only
            if (trn && req.wen && ofs_out) begin
                for (int b = 0; b < `TCB_BEN; b++) begin
                    if (req.ben[b]) begin
                        gpio_out[8*b +: 8] <= req.wdt[8*b +: 8];
                    end
                end
            end
        end
    end

    // read mux registered on the handshake edge
    always_ff @(posedge clk) begin
        if (trn) begin
            if (req.wen) rdt <= '0;
            else         rdt <= ofs_in ? gpio_sync1 : gpio_out;
        end
    end

    assign rsp.rdt = rdt;
    assign rsp.err = 1'b0;

endmodule

// File: design/tcb_sram_sub.sv
`timescale 1ns/1ps

/*
 * tcb memory subordinate, DEPTH words of 32 bits
 * byte enabled writes, registered reads, no wait states
 */

`include "tcb_macros.svh"

module tcb_sram_sub #(
    // number of words
    parameter  int unsigned DEPTH = 256,
    localparam int unsigned AW    = $clog2(DEPTH)
)(
    input  logic              clk,
    // subordinate port
    input  logic              vld,
    input  tcb_pkg::tcb_req_t req,
    output logic              rdy,
    output tcb_pkg::tcb_rsp_t rsp
);

    // storage
    logic [`TCB_DAT-1:0] mem [DEPTH];
    // word index
    logic [AW-1:0]       idx;
    // response data register
    logic [`TCB_DAT-1:0] rdt;
    // handshake
    logic                trn;

    //////////////////////////////////////////////////
    // request
    //////////////////////////////////////////////////

    // always ready, no wait states
    assign rdy = 1'b1;
    assign trn = vld && rdy;

    // byte address to word index, bits 9:2 for 256 words
    assign idx = req.adr[AW+1:2];

    //////////////////////////////////////////////////
    // memory array
    //////////////////////////////////////////////////

    // write only the enabled bytes
    always_ff @(posedge clk) begin
        if (trn && req.wen) begin
            for (int b = 0; b < `TCB_BEN; b++) begin
                if (req.ben[b]) begin
                    mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////

    // read data lands on the handshake edge
    // writes return zero
    always_ff @(posedge clk) begin
        if (trn) begin
            rdt <= req.wen ? '0 : mem[idx];
        end
    end

    // the memory never reports an error
    assign rsp.rdt = rdt;
    assign rsp.err = 1'b0;

endmodule

// File: design/tcb_demux.sv
`timescale 1ns/1ps

/*
 * tcb demultiplexer, one manager to IFN subordinates
 * forwards the request to the decoded subordinate and returns its response
 * one cycle later, unmapped addresses get an error response
 */

module tcb_demux #(
    // subordinate count
    parameter  int unsigned IFN = 2,
    localparam int unsigned IFL = $clog2(IFN)
)(
    input  logic                        clk,
    input  logic                        arst_n,
    // manager port
    input  logic                        man_vld,
    input  tcb_pkg::tcb_req_t           man_req,
    output logic                        man_rdy,
    output logic                        man_rsp_vld,
    output tcb_pkg::tcb_rsp_t           man_rsp,
    // decoder result for man_req
    input  logic [IFL-1:0]              sel,
    input  logic                        hit,
    // subordinate ports
    output logic [IFN-1:0]              sub_vld,
    output tcb_pkg::tcb_req_t           sub_req,
    input  logic [IFN-1:0]              sub_rdy,
    input  tcb_pkg::tcb_rsp_t [IFN-1:0] sub_rsp
);

    import tcb_pkg::*;

    // handshake this cycle
    logic           trn;
    // response stage state
    logic           rsp_vld;
    logic           rsp_hit;
    logic [IFL-1:0] rsp_sel;
    // fixed error response
    tcb_rsp_t       rsp_err;

    //////////////////////////////////////////////////
    // request stage
    //////////////////////////////////////////////////

    // payload goes to every subordinate, only vld is steered
    assign sub_req = man_req;

    always_comb begin
        for (int i = 0; i < IFN; i++) begin
            sub_vld[i] = man_vld && hit && (sel == IFL'(i));
        end
    end

    // a miss is always accepted, the demux answers it itself
    assign man_rdy = hit ? sub_rdy[sel] : 1'b1;

    assign trn = man_vld && man_rdy;

    //////////////////////////////////////////////////
    // response stage
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_vld <= 1'b0;
            rsp_hit <= 1'b0;
            rsp_sel <= '0;
        end else begin
            // response valid for exactly one cycle per transfer
            rsp_vld <= trn;
            // remember who owes the response
            if (trn) begin
                rsp_hit <= hit;
                rsp_sel <= sel;
            end
        end
    end

    // err set, no read data
    assign rsp_err = '{rdt: '0, err: 1'b1};

    assign man_rsp_vld = rsp_vld;
    // subordinates register on the handshake edge, so pick directly
    assign man_rsp = rsp_hit ? sub_rsp[rsp_sel] : rsp_err;

    //////////////////////////////////////////////////
    // assertions
    //////////////////////////////////////////////////

    // never more than one subordinate addressed
    assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(sub_vld))
        else $error("more than one sub_vld active");

    // every response belongs to a handshake one cycle earlier
    assert property (@(posedge clk) disable iff (!arst_n)
        man_rsp_vld |-> $past(man_vld && man_rdy))
        else $error("man_rsp_vld without a preceding handshake");

endmodule

// File: design/tcb_decoder.sv
`timescale 1ns/1ps

/*
 * tcb address decoder
 * wildcard match against an address/mask table, lowest matching entry wins
 */

`include "tcb_macros.svh"

module tcb_decoder #(
    // subordinate count
    parameter  int unsigned IFN = 2,
    localparam int unsigned IFL = $clog2(IFN),
    // address/mask table, x bits are don't care
    parameter  logic [`TCB_ADR-1:0] DAM [IFN-1:0] = '{default: '0}
)(
    input  logic [`TCB_ADR-1:0] adr,
    output logic [IFL-1:0]      sel,
    output logic                hit
);

    //////////////////////////////////////////////////
    // match
    //////////////////////////////////////////////////

    // one flag per table entry
    logic [IFN-1:0] mch;

    for (genvar i = 0; i < IFN; i++) begin : g_mch
        // wildcard equality, x/z in the pattern match anything
        assign mch[i] = (adr ==? DAM[i]);
    end

    //////////////////////////////////////////////////
    // encode
    //////////////////////////////////////////////////

    // priority encoder, lowest index has priority
    function automatic logic [IFL-1:0] encode(logic [IFN-1:0] val);
        logic [IFL-1:0] idx;
        idx = '0;
        // walk down so the lowest set bit is the last one kept
        for (int i = IFN - 1; i >= 0; i--) begin
            if (val[i]) begin
                idx = IFL'(i);
            end
        end
        return idx;
    endfunction

    assign sel = encode(mch);
    // any entry matched
    assign hit = |mch;

    // overlapping windows in the table
    // evaluated after the match vector settles
    always_comb begin
        assert final ($onehot0(mch))
            else $error("address %h matches more than one decoder entry", adr);
    end

endmodule

// File: design/tcb_pkg.sv
/*
 * tcb request and response payload types
 * shared by the decoder, demux and all subordinates
 */

`include "tcb_macros.svh"

package tcb_pkg;

    //////////////////////////////////////////////////
    // request
    //////////////////////////////////////////////////

    // one transfer from manager to subordinate
    typedef struct packed {
        // write enable, 0 for read
        logic                wen;
        // byte address
        logic [`TCB_ADR-1:0] adr;
        // byte enables, writes only
        logic [`TCB_BEN-1:0] ben;
        // write data
        logic [`TCB_DAT-1:0] wdt;
    } tcb_req_t;

    //////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////

    // returned one cycle after the handshake
    typedef struct packed {
        // read data, zero on writes
        logic [`TCB_DAT-1:0] rdt;
        // unmapped address
        logic                err;
    } tcb_rsp_t;

endpackage

// File: design/tcb_macros.svh
/*
 * tcb bus widths, subordinate count and memory map
 * address/mask patterns use x bits as wildcards
 */

`ifndef TCB_MACROS_SVH
`define TCB_MACROS_SVH

// bus widths
`define TCB_ADR 32
`define TCB_DAT 32
`define TCB_BEN 4

// number of subordinates behind the demux
`define TCB_IFN 2

// memory window 0x0000_0000 to 0x0000_03ff
`define TCB_DAM_SRAM 32'b0000_0000_0000_0000_0000_00xx_xxxx_xxxx
// gpio window 0x0001_0000 to 0x0001_0007
`define TCB_DAM_GPIO 32'b0000_0000_0000_0001_0000_0000_0000_0xxx

// gpio register offsets
`define GPIO_OFS_OUT 0
`define GPIO_OFS_IN  4

`endif
